//--- stats_defines.svh
// Widths and counts of the statistics path, included by RTL and testbench sources
`ifndef STATS_DEFINES_SVH
`define STATS_DEFINES_SVH

// Increment sources feeding the arbiter
`define STAT_PORTS 2

// Counter index width and number of counters
`define STAT_ID_W 5
`define STAT_COUNT 32

// One increment amount
`define STAT_INC_W 16

// Width of each accumulated counter
`define STAT_COUNT_W 64

// Cycles from host read strobe to read response
`define STAT_RD_LATENCY 2

`endif

//--- stats_pkg.sv
// Struct types for statistic increments and counter read responses, imported by all stats blocks
`include "stats_defines.svh"

package stats_pkg;

    // One increment event from a port
    // Index selects the counter, inc is the amount added
    typedef struct packed {
        logic [`STAT_ID_W-1:0]  id;
        logic [`STAT_INC_W-1:0] inc;
    } stat_inc_t;

    // Host read response
    // Valid for exactly one cycle per accepted strobe
    typedef struct packed {
        logic                     valid;
        logic [`STAT_COUNT_W-1:0] data;
    } stat_rd_rsp_t;

endpackage

//--- stat_arb_mux.sv
// Round-robin merge of the per-port increment streams into one registered stream for the counter bank
`timescale 1ns/1ps
`include "stats_defines.svh"

module stat_arb_mux (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // Increment inputs, one per port
    input  stats_pkg::stat_inc_t      s_stat_i [`STAT_PORTS],
    input  logic [`STAT_PORTS-1:0]    s_valid_i,
    output logic [`STAT_PORTS-1:0]    s_ready_o,

    // Merged output towards the counter bank
    output stats_pkg::stat_inc_t      m_stat_o,
    output logic                      m_valid_o,
    input  logic                      m_ready_i
);

    import stats_pkg::*;

    // Round-robin pointer, first port to be considered
    logic [$clog2(`STAT_PORTS)-1:0] rr_ptr_q;
    logic [$clog2(`STAT_PORTS)-1:0] grant_idx;
    logic [$clog2(`STAT_PORTS)-1:0] grant_nxt;
    logic                           grant_found;
    logic                           can_load;

    // Output register of depth one
    stat_inc_t                      m_stat_q;
    logic                           m_valid_q;

    // The slot only turns over while the bank takes data.
    // A stalled bank freezes the slot and closes every input
    assign can_load = m_ready_i;

    // Search from the pointer for the first valid port
    always_comb begin : grant_sel
        int idx;
        int nxt;
        grant_found = 1'b0;
        grant_idx   = rr_ptr_q;
        grant_nxt   = rr_ptr_q;
        for (int k = 0; k < `STAT_PORTS; k++) begin
            idx = (int'(rr_ptr_q) + k) % `STAT_PORTS;
            nxt = (idx + 1) % `STAT_PORTS;
            if (!grant_found && s_valid_i[idx]) begin
                grant_found = 1'b1;
                grant_idx   = idx[$clog2(`STAT_PORTS)-1:0];
                grant_nxt   = nxt[$clog2(`STAT_PORTS)-1:0];
            end
        end
    end

    // One-hot ready towards the granted port only
    always_comb begin
        s_ready_o = '0;
        if (can_load && grant_found) begin
            s_ready_o[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            m_valid_q <= 1'b0;
            rr_ptr_q  <= '0;
        end else if (can_load) begin
            m_valid_q <= grant_found;
            // Next search starts after the winner
            if (grant_found) begin
                rr_ptr_q <= grant_nxt;
            end
        end
    end

    // Payload, follows the valid bit
    always_ff @(posedge clk) begin
        if (can_load && grant_found) begin
            m_stat_q <= s_stat_i[grant_idx];
        end
    end

    assign m_stat_o  = m_stat_q;
    assign m_valid_o = m_valid_q;

endmodule

//--- stat_counter_bank.sv
// Bank of 64-bit statistic counters with clear sweep, read-add-write pipeline and host read port
`timescale 1ns/1ps
`include "stats_defines.svh"

module stat_counter_bank (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // Increment input from the arbiter
    input  stats_pkg::stat_inc_t      s_stat_i,
    input  logic                      s_valid_i,
    output logic                      s_ready_o,

    // Host read port
    input  logic                      rd_en_i,
    input  logic [`STAT_ID_W-1:0]     rd_addr_i,
    output stats_pkg::stat_rd_rsp_t   rd_rsp_o
);

    import stats_pkg::*;

    // Counter storage, one write and one read port
    logic [`STAT_COUNT_W-1:0] mem [`STAT_COUNT];
    logic [`STAT_COUNT_W-1:0] mem_rdata_q;
    logic [`STAT_ID_W-1:0]    mem_raddr;
    logic                     mem_we;
    logic [`STAT_ID_W-1:0]    mem_waddr;
    logic [`STAT_COUNT_W-1:0] mem_wdata;

    // Clearing sweep after reset
    logic                     clr_active_q;
    logic [`STAT_ID_W-1:0]    clr_addr_q;

    // Stage 1 holds the accepted increment while its counter is read
    logic                     p1_valid_q;
    stat_inc_t                p1_stat_q;

    // Stage 2 adds and writes back
    logic                     p2_valid_q;
    stat_inc_t                p2_stat_q;
    logic [`STAT_COUNT_W-1:0] p2_base;
    logic [`STAT_COUNT_W-1:0] p2_sum;

    // Bypass for a same-index increment one cycle behind
    logic                     fwd_hit_q;
    logic [`STAT_COUNT_W-1:0] fwd_sum_q;

    // Host read bookkeeping
    logic                     rd_pend_q;
    logic [`STAT_ID_W-1:0]    rd_addr_q;
    logic                     rd_valid_q;

    logic                     accept;

    // A strobe claims the read port in the next cycle, so hold off input now
    assign s_ready_o = !clr_active_q && !rd_en_i;
    assign accept    = s_valid_i && s_ready_o;

    // Read port is free for the host in the cycle after a strobe
    assign mem_raddr = rd_pend_q ? rd_addr_q : p1_stat_q.id;

    assign p2_base = fwd_hit_q ? fwd_sum_q : mem_rdata_q;
    assign p2_sum  = p2_base + {{(`STAT_COUNT_W-`STAT_INC_W){1'b0}}, p2_stat_q.inc};

    // Sweep owns the write port until it finishes
    assign mem_we    = clr_active_q || p2_valid_q;
    assign mem_waddr = clr_active_q ? clr_addr_q : p2_stat_q.id;
    assign mem_wdata = clr_active_q ? '0 : p2_sum;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        mem_rdata_q <= mem[mem_raddr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            clr_active_q <= 1'b1;
            clr_addr_q   <= '0;
            p1_valid_q   <= 1'b0;
            p2_valid_q   <= 1'b0;
            fwd_hit_q    <= 1'b0;
            rd_pend_q    <= 1'b0;
            rd_valid_q   <= 1'b0;
        end else begin
            if (clr_active_q) begin
                clr_addr_q <= clr_addr_q + 1'b1;
                if (int'(clr_addr_q) == `STAT_COUNT - 1) begin
                    clr_active_q <= 1'b0;
                end
            end

            p1_valid_q <= accept;
            p2_valid_q <= p1_valid_q;

            // Write at this edge is not yet visible to the read below
            fwd_hit_q <= p1_valid_q && p2_valid_q && (p1_stat_q.id == p2_stat_q.id);

            // Strobes during the sweep are dropped
            rd_pend_q  <= rd_en_i && !clr_active_q;
            rd_valid_q <= rd_pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p1_stat_q <= s_stat_i;
        end
        p2_stat_q <= p1_stat_q;
        fwd_sum_q <= p2_sum;
        if (rd_en_i) begin
            rd_addr_q <= rd_addr_i;
        end
    end

    assign rd_rsp_o = '{valid: rd_valid_q, data: mem_rdata_q};

endmodule

//--- stats_top.sv
// Top of the statistics path: increment arbiter feeding the counter bank, with host read access
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_top (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // Increment streams from the network ports
    input  stats_pkg::stat_inc_t      s_stat_i [`STAT_PORTS],
    input  logic [`STAT_PORTS-1:0]    s_valid_i,
    output logic [`STAT_PORTS-1:0]    s_ready_o,

    // Host counter read
    input  logic                      rd_en_i,
    input  logic [`STAT_ID_W-1:0]     rd_addr_i,
    output stats_pkg::stat_rd_rsp_t   rd_rsp_o
);

    import stats_pkg::*;

    // Merged stream between arbiter and bank
    stat_inc_t arb_stat;
    logic      arb_valid;
    logic      bank_ready;

    stat_arb_mux stat_arb_mux_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),

        .s_stat_i  (s_stat_i),
        .s_valid_i (s_valid_i),
        .s_ready_o (s_ready_o),

        .m_stat_o  (arb_stat),
        .m_valid_o (arb_valid),
        .m_ready_i (bank_ready)
    );

    // Bank stalls the arbiter while clearing and on host reads
    stat_counter_bank stat_counter_bank_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),

        .s_stat_i  (arb_stat),
        .s_valid_i (arb_valid),
        .s_ready_o (bank_ready),

        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_rsp_o  (rd_rsp_o)
    );

endmodule

//--- stats_assert.sv
// Concurrent protocol checks of the statistics path, attached to the top level with bind
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_assert (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic [`STAT_PORTS-1:0]   s_ready_i,
    input logic                     bank_ready_i,
    input logic                     rd_en_i,
    input stats_pkg::stat_rd_rsp_t  rd_rsp_i
);

    import stats_pkg::*;

    // Number of failed checks
    int unsigned fail_count = 0;

    // Bank has finished its clearing sweep
    logic        sweep_done_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sweep_done_q <= 1'b0;
        end else if (bank_ready_i) begin
            sweep_done_q <= 1'b1;
        end
    end

    ready_one_hot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(s_ready_i))
        else begin
            $error("more than one increment port ready in one cycle");
            fail_count++;
        end

    read_response: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_en_i && sweep_done_q |-> ##`STAT_RD_LATENCY rd_rsp_i.valid)
        else begin
            $error("read strobe without response after the read latency");
            fail_count++;
        end

    no_stray_response: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_rsp_i.valid |-> $past(rd_en_i, `STAT_RD_LATENCY))
        else begin
            $error("read response without a matching strobe");
            fail_count++;
        end

endmodule

bind stats_top stats_assert stats_assert_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .s_ready_i    (s_ready_o),
    .bank_ready_i (bank_ready),
    .rd_en_i      (rd_en_i),
    .rd_rsp_i     (rd_rsp_o)
);

//--- tb_stats_top.sv
// Directed testbench for the statistics path, drives both increment ports and reads counters back
`timescale 1ns/1ps
`include "stats_defines.svh"

module tb_stats_top;

    import stats_pkg::*;

    localparam int SEND_LIMIT = 200;
    localparam int READ_LIMIT = 10;
    localparam int GEN_MAX    = 100;

    logic                     clk;
    logic                     rst_n_i;
    stat_inc_t                s_stat_i [`STAT_PORTS];
    logic [`STAT_PORTS-1:0]   s_valid_i;
    logic [`STAT_PORTS-1:0]   s_ready_o;
    logic                     rd_en_i;
    logic [`STAT_ID_W-1:0]    rd_addr_i;
    stat_rd_rsp_t             rd_rsp_o;

    // Reference sums, one per counter
    logic [`STAT_COUNT_W-1:0] model_sum [`STAT_COUNT];
    int                       last_port;
    int                       checks;
    int                       errors;
    logic [31:0]              rng_state;

    // Stimulus per port, generated before each test
    logic [`STAT_ID_W-1:0]    gen_id  [`STAT_PORTS][GEN_MAX];
    logic [`STAT_INC_W-1:0]   gen_inc [`STAT_PORTS][GEN_MAX];
    int                       gen_gap [`STAT_PORTS][GEN_MAX];

    stats_top uut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .s_stat_i  (s_stat_i),
        .s_valid_i (s_valid_i),
        .s_ready_o (s_ready_o),
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_rsp_o  (rd_rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reference model, updated on every accepted increment
    always @(posedge clk) begin
        if (rst_n_i) begin
            for (int p = 0; p < `STAT_PORTS; p++) begin
                if (s_valid_i[p] && s_ready_o[p]) begin
                    model_sum[s_stat_i[p].id] += 64'(s_stat_i[p].inc);
                    // With both ports waiting the grant must switch
                    if (&s_valid_i && last_port >= 0) begin
                        checks++;
                        assert (p != last_port) else begin
                            $display("[FAIL] %0t: port %0d granted twice while the other waited",
                                     $time, p);
                            errors++;
                        end
                    end
                    last_port = p;
                end
            end
        end
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic finish_run();
        int total;
        total = errors + int'(uut.stats_assert_inst.fail_count);
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.stats_assert_inst.fail_count);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%0t: %s finished with %0d errors", $time, name, errors - err_before);
    endtask

    task automatic compare_value(input logic [`STAT_COUNT_W-1:0] got,
                                 input logic [`STAT_COUNT_W-1:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Called and returns on a falling edge
    task automatic send_inc(input int p, input logic [`STAT_ID_W-1:0] idx,
                            input logic [`STAT_INC_W-1:0] amount, input int limit);
        int   waited;
        logic accepted;
        s_stat_i[p]  = '{id: idx, inc: amount};
        s_valid_i[p] = 1'b1;
        waited       = 0;
        accepted     = 1'b0;
        while (!accepted && waited < limit) begin
            @(posedge clk);
            accepted = s_ready_o[p];
            waited++;
        end
        if (!accepted) begin
            $display("Timeout: port %0d saw no ready within %0d cycles", p, limit);
            errors++;
            finish_run();
        end else begin
            @(negedge clk);
            s_valid_i[p] = 1'b0;
        end
    endtask

    task automatic read_counter(input logic [`STAT_ID_W-1:0] addr, input bit check_data);
        int   lat;
        logic seen;
        rd_en_i   = 1'b1;
        rd_addr_i = addr;
        @(negedge clk);
        rd_en_i = 1'b0;
        lat     = 1;
        seen    = rd_rsp_o.valid;
        while (!seen && lat < READ_LIMIT) begin
            @(negedge clk);
            lat++;
            seen = rd_rsp_o.valid;
        end
        if (!seen) begin
            $display("Timeout: no read response for counter %0d", addr);
            errors++;
            finish_run();
        end else begin
            compare_value(64'(lat), 64'(`STAT_RD_LATENCY),
                          $sformatf("read latency of counter %0d", addr));
            if (check_data) begin
                compare_value(rd_rsp_o.data, model_sum[addr], $sformatf("counter %0d", addr));
            end
        end
    endtask

    task automatic read_all();
        for (int a = 0; a < `STAT_COUNT; a++) begin
            read_counter(a[`STAT_ID_W-1:0], 1'b1);
        end
    endtask

    // Idle long enough for the last increment to reach memory
    task automatic drain();
        repeat (6) @(negedge clk);
    endtask

    task automatic fill_stimulus(input int max_gap);
        logic [31:0] rnd;
        for (int p = 0; p < `STAT_PORTS; p++) begin
            for (int i = 0; i < GEN_MAX; i++) begin
                rnd           = xorshift32();
                gen_id[p][i]  = rnd[`STAT_ID_W-1:0];
                gen_inc[p][i] = rnd[16 +: `STAT_INC_W];
                gen_gap[p][i] = (max_gap > 0) ? int'(rnd[10:8]) % (max_gap + 1) : 0;
            end
        end
    endtask

    task automatic stream_port(input int p, input int n);
        for (int i = 0; i < n; i++) begin
            repeat (gen_gap[p][i]) @(negedge clk);
            send_inc(p, gen_id[p][i], gen_inc[p][i], SEND_LIMIT);
        end
    endtask

    task automatic sweep_read_ignored();
        rd_en_i   = 1'b1;
        rd_addr_i = '0;
        @(negedge clk);
        rd_en_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checks++;
            assert (!rd_rsp_o.valid) else begin
                $display("[FAIL] %0t: read during clearing sweep got a response", $time);
                errors++;
            end
        end
    endtask

    task automatic reset_clear();
        int err_before;
        err_before = errors;
        checks++;
        assert (s_ready_o == '0 && !rd_rsp_o.valid) else begin
            $display("[FAIL] %0t: ready or read valid high right after reset", $time);
            errors++;
        end
        fork
            // Zero amount leaves every counter at zero
            send_inc(0, '0, '0, `STAT_COUNT + 10);
            sweep_read_ignored();
        join
        read_all();
        report_test("reset_clear", err_before);
    endtask

    task automatic single_port_series();
        int                    err_before;
        logic [31:0]           rnd;
        logic [`STAT_ID_W-1:0] idx;
        err_before = errors;
        // Back-to-back hits on one counter
        for (int i = 0; i < 4; i++) begin
            send_inc(0, 'd5, 100 + i, SEND_LIMIT);
        end
        idx = '0;
        for (int i = 0; i < 24; i++) begin
            rnd = xorshift32();
            if (i % 3 != 2) begin
                idx = rnd[20 +: `STAT_ID_W];
            end
            send_inc(0, idx, rnd[`STAT_INC_W-1:0], SEND_LIMIT);
        end
        drain();
        read_all();
        report_test("single_port_series", err_before);
    endtask

    task automatic port_alternation();
        int err_before;
        err_before = errors;
        fill_stimulus(0);
        fork
            stream_port(0, 16);
            stream_port(1, 16);
        join
        drain();
        read_all();
        report_test("port_alternation", err_before);
    endtask

    task automatic reads_under_traffic();
        int err_before;
        err_before = errors;
        fill_stimulus(0);
        fork
            stream_port(0, 20);
            stream_port(1, 20);
            begin
                for (int i = 0; i < 8; i++) begin
                    repeat (2) @(negedge clk);
                    read_counter(gen_id[0][i * 2], 1'b0);
                end
            end
        join
        drain();
        read_all();
        report_test("reads_under_traffic", err_before);
    endtask

    task automatic random_burst();
        int err_before;
        err_before = errors;
        fill_stimulus(3);
        fork
            stream_port(0, GEN_MAX);
            stream_port(1, GEN_MAX);
        join
        drain();
        read_all();
        report_test("random_burst", err_before);
    endtask

    initial begin
        rst_n_i   = 1'b0;
        s_valid_i = '0;
        for (int p = 0; p < `STAT_PORTS; p++) begin
            s_stat_i[p] = '0;
        end
        rd_en_i    = 1'b0;
        rd_addr_i  = '0;
        rng_state  = 32'h4a6a_38e4;
        last_port  = -1;
        checks     = 0;
        errors     = 0;
        for (int a = 0; a < `STAT_COUNT; a++) begin
            model_sum[a] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        reset_clear();
        single_port_series();
        port_alternation();
        reads_under_traffic();
        random_burst();
        finish_run();
    end

endmodule

//--- all.f
+incdir+.
stats_pkg.sv
stat_arb_mux.sv
stat_counter_bank.sv
stats_top.sv
stats_assert.sv
tb_stats_top.sv
